/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_eg -o tb_eg || exit 1
out=$(./obj_dir/tb_eg 2>&1)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sources.f */
+incdir+src
src/eg_pkg.sv
src/eg_delay_line.sv
src/eg_timer.sv
src/eg_slot_regs.sv
src/eg_envelope.sv
src/eg_top.sv
test/tb_eg.sv

/* src/eg_config.svh */
// envelope generator build constants
// slot count, loop lengths and output latency
`ifndef EG_CONFIG_SVH
`define EG_CONFIG_SVH

`define EG_SLOTS        32
`define EG_MAX_ATT      1023

// level loop from stage VII back to stage II
`define EG_LOOP_STAGES  27
// phase loop from stage III back to stage II
`define EG_STATE_STAGES 31
`define EG_TAP_STAGES   4   // stage II to VI
`define EG_PAD_STAGES   3   // output padding after stage VIII

`define EG_LATENCY      10

`endif

/* src/eg_delay_line.sv */
// clock-enabled shift register with reset value
// closes the slot loops and pads the output
`timescale 1ns/100ps

module eg_delay_line #(
    parameter int               width   = 1,
    parameter int               stages  = 1,
    parameter logic [width-1:0] rst_val = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);

    logic [width-1:0] sh [stages];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < stages; i++)
                sh[i] <= rst_val;
        end else if (cen) begin
            sh[0] <= din;
            for (int i = 1; i < stages; i++)
                sh[i] <= sh[i-1];
        end
    end

    assign dout = sh[stages-1];

    a_stages: assert property (@(posedge clk) stages >= 1);

endmodule

/* src/eg_envelope.sv */
// envelope pipeline, stages I to XI
// phase and rate select, step decision, level update, tl and am sum
`timescale 1ns/100ps
`include "eg_config.svh"

module eg_envelope (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              zero,
    input  logic [14:0]       eg_cnt,
    input  eg_pkg::d1l_t      d1l_i,
    input  eg_pkg::rate_t     arate_ii,
    input  eg_pkg::rate_t     rate1_ii,
    input  eg_pkg::rate_t     rate2_ii,
    input  eg_pkg::rrate_t    rrate_ii,
    input  logic              keyon_ii,
    input  eg_pkg::keycode_t  keycode_iii,
    input  eg_pkg::ks_t       ks_iii,
    input  eg_pkg::tl_t       tl_vii,
    input  eg_pkg::ams_t      ams_vii,
    input  logic              amsen_vii,
    input  logic [6:0]        am,
    output logic              pg_rst,
    output eg_pkg::level_t    eg_out
);

    localparam eg_pkg::level_t MAX_ATT = eg_pkg::level_t'(`EG_MAX_ATT);

    eg_pkg::eg_phase_t state_ii, state_in_iii, state_in_iv, state_in_v, state_in_vi;
    eg_pkg::level_t    eg_ii, eg_vi, eg_vii, eg_viii;
    eg_pkg::rate_t     cfg_iii;
    logic [1:0]        state_ii_raw;
    logic [10:0]       tap_vi;
    logic [4:0]        d1level_ii;
    logic              keyon_last_ii, keyon_now_ii, keyoff_now_ii, ar_off_ii, ar_off_vi;
    logic [6:0]        pre_rate_iii;
    logic [5:0]        rate_iv, rate_v;
    logic [5:1]        rate_vi;
    logic [3:0]        cnt_base_iv, cnt_shift_iv;
    logic [2:0]        cnt_v;
    logic              cnt_last_v, step_v, step_vi, sum_up_vi;
    logic [7:0]        step_idx_v;
    logic [8:0]        ar_sum0_vi, am_final_vii;
    logic [9:0]        ar_sum_vi, ar_result_vi, dec_step_vi;
    logic [11:0]       sum_vii;

    // I: decay1 level in 3 dB steps, 15 maps to 48 dB
    always_ff @(posedge clk) begin
        if (cen) begin
            d1level_ii <= (d1l_i == 4'd15) ? 5'h10 : {1'b0, d1l_i};
        end
    end

    // II: key edges against the previous frame
    assign state_ii      = eg_pkg::eg_phase_t'(state_ii_raw);
    assign keyon_now_ii  = !keyon_last_ii && keyon_ii;
    assign keyoff_now_ii = keyon_last_ii && !keyon_ii;
    assign ar_off_ii     = keyon_now_ii && (arate_ii == 5'h1f);

    always_ff @(posedge clk) begin
        if (rst) begin
            pg_rst       <= 1'b0;
            state_in_iii <= eg_pkg::RELEASE;
            cfg_iii      <= '0;
        end else if (cen) begin
            pg_rst <= keyon_now_ii;
            if (keyoff_now_ii) begin
                state_in_iii <= eg_pkg::RELEASE;
                cfg_iii      <= {rrate_ii, 1'b1};
            end else if (keyon_now_ii) begin
                state_in_iii <= eg_pkg::ATTACK;
                cfg_iii      <= arate_ii;
            end else begin
                case (state_ii)
                    eg_pkg::ATTACK: begin
                        if (eg_ii == '0) begin  // attack peak reached
                            state_in_iii <= eg_pkg::DECAY1;
                            cfg_iii      <= rate1_ii;
                        end else begin
                            state_in_iii <= eg_pkg::ATTACK;
                            cfg_iii      <= arate_ii;
                        end
                    end
                    eg_pkg::DECAY1: begin
                        if (eg_ii[9:5] >= d1level_ii) begin
                            state_in_iii <= eg_pkg::DECAY2;
                            cfg_iii      <= rate2_ii;
                        end else begin
                            state_in_iii <= eg_pkg::DECAY1;
                            cfg_iii      <= rate1_ii;
                        end
                    end
                    eg_pkg::DECAY2: begin
                        state_in_iii <= eg_pkg::DECAY2;
                        cfg_iii      <= rate2_ii;
                    end
                    default: begin
                        state_in_iii <= eg_pkg::RELEASE;
                        cfg_iii      <= {rrate_ii, 1'b1};
                    end
                endcase
            end
        end
    end

    // III: key scaling, a zero rate stays zero
    always_comb begin
        pre_rate_iii = {1'b0, cfg_iii, 1'b0} + 7'(keycode_iii >> (2'd3 - ks_iii));
        if (cfg_iii == '0)
            pre_rate_iii = '0;
    end

    // IV: counter tap, attack runs one octave faster
    assign cnt_base_iv  = (state_in_iv == eg_pkg::ATTACK) ? 4'd11 : 4'd12;
    assign cnt_shift_iv = (rate_iv[5:2] >= cnt_base_iv) ? 4'd0 : cnt_base_iv - rate_iv[5:2];

    // V: step pattern over eight counter phases
    always_comb begin
        if (rate_v[5:4] == 2'b11) begin
            if (rate_v[5:2] == 4'hf && state_in_v == eg_pkg::ATTACK)
                step_idx_v = 8'b11111111;  // fastest attack
            else
                case (rate_v[1:0])
                    2'd0:    step_idx_v = 8'b00000000;
                    2'd1:    step_idx_v = 8'b10001000;
                    2'd2:    step_idx_v = 8'b10101010;
                    default: step_idx_v = 8'b11101110;
                endcase
        end else if (rate_v[5:2] == 4'd0 && state_in_v != eg_pkg::ATTACK) begin
            step_idx_v = 8'b11111110;  // slowest decay limit
        end else begin
            case (rate_v[1:0])
                2'd0:    step_idx_v = 8'b10101010;
                2'd1:    step_idx_v = 8'b11101010;
                2'd2:    step_idx_v = 8'b11101110;
                default: step_idx_v = 8'b11111110;
            endcase
        end
        step_v = (rate_v[5:1] == 5'd0) ? 1'b0 : step_idx_v[cnt_v];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_in_iv <= eg_pkg::RELEASE;
            state_in_v  <= eg_pkg::RELEASE;
            state_in_vi <= eg_pkg::RELEASE;
            rate_iv     <= '0;
            rate_v      <= '0;
            rate_vi     <= '0;
            cnt_v       <= '0;
            step_vi     <= 1'b0;
            sum_up_vi   <= 1'b0;
        end else if (cen) begin
            state_in_iv <= state_in_iii;
            rate_iv     <= pre_rate_iii[6] ? 6'd63 : pre_rate_iii[5:0];
            state_in_v  <= state_in_iv;
            rate_v      <= rate_iv;
            cnt_v       <= 3'(eg_cnt >> cnt_shift_iv);
            state_in_vi <= state_in_v;
            rate_vi     <= rate_v[5:1];
            step_vi     <= step_v;
            sum_up_vi   <= cnt_v[0] != cnt_last_v;  // tap bit toggled since last frame
        end
    end

    // VI: attack shrinks by a fraction of the level, decay adds a small step
    always_comb begin
        casez (rate_vi[5:2])
            4'b1101: ar_sum0_vi = {2'd0, eg_vi[9:3]} + 9'd1;
            4'b111?: ar_sum0_vi = {1'd0, eg_vi[9:2]} + 9'd1;
            default: ar_sum0_vi = {3'd0, eg_vi[9:4]} + 9'd1;
        endcase
        if (rate_vi[5:4] == 2'b11)
            ar_sum_vi = step_vi ? {ar_sum0_vi, 1'b0} : {1'b0, ar_sum0_vi};
        else
            ar_sum_vi = step_vi ? {1'b0, ar_sum0_vi} : 10'd0;
        ar_result_vi = (ar_sum_vi < eg_vi) ? eg_vi - ar_sum_vi : 10'd0;
        case (rate_vi[5:2])
            4'b1100: dec_step_vi = {8'd0, step_vi, ~step_vi};
            4'b1101: dec_step_vi = {7'd0, step_vi, ~step_vi, 1'b0};
            4'b1110: dec_step_vi = {6'd0, step_vi, ~step_vi, 2'b0};
            4'b1111: dec_step_vi = 10'd8;
            default: dec_step_vi = {8'd0, step_vi, 1'b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eg_vii <= MAX_ATT;
        end else if (cen) begin
            if (ar_off_vi) begin
                eg_vii <= '0;  // ar 31 jumps straight to peak
            end else if (state_in_vi == eg_pkg::ATTACK) begin
                if (sum_up_vi && eg_vi != '0)
                    eg_vii <= (rate_vi == 5'h1f) ? 10'd0 : ar_result_vi;
                else
                    eg_vii <= eg_vi;
            end else if (sum_up_vi) begin
                eg_vii <= (eg_vi <= MAX_ATT - 10'd8) ? eg_vi + dec_step_vi : MAX_ATT;
            end else begin
                eg_vii <= eg_vi;
            end
        end
    end

    // VII: level plus tl and am depth, saturated
    always_comb begin
        case ({amsen_vii, ams_vii})
            3'b101:  am_final_vii = {2'b00, am};
            3'b110:  am_final_vii = {1'b0, am, 1'b0};
            3'b111:  am_final_vii = {am, 2'b00};
            default: am_final_vii = '0;
        endcase
        sum_vii = {2'b0, tl_vii, 3'd0} + {2'b0, eg_vii} + {3'b0, am_final_vii};
    end

    always_ff @(posedge clk) begin
        if (rst)
            eg_viii <= MAX_ATT;
        else if (cen)
            eg_viii <= (sum_vii[11:10] != 2'b0 || tl_vii == 7'h7f) ? MAX_ATT : sum_vii[9:0];
    end

    assign {ar_off_vi, eg_vi} = tap_vi;

    eg_delay_line #(.width(10), .stages(`EG_LOOP_STAGES), .rst_val(MAX_ATT)) u_level_loop (
        .clk(clk), .rst(rst), .cen(cen), .din(eg_vii), .dout(eg_ii)
    );

    eg_delay_line #(.width(11), .stages(`EG_TAP_STAGES), .rst_val({1'b0, MAX_ATT})) u_level_tap (
        .clk(clk), .rst(rst), .cen(cen), .din({ar_off_ii, eg_ii}), .dout(tap_vi)
    );

    eg_delay_line #(.width(1), .stages(`EG_SLOTS), .rst_val(1'b0)) u_key_loop (
        .clk(clk), .rst(rst), .cen(cen), .din(keyon_ii), .dout(keyon_last_ii)
    );

    eg_delay_line #(.width(1), .stages(`EG_SLOTS), .rst_val(1'b0)) u_cnt_loop (
        .clk(clk), .rst(rst), .cen(cen), .din(cnt_v[0]), .dout(cnt_last_v)
    );

    eg_delay_line #(.width(2), .stages(`EG_STATE_STAGES), .rst_val(eg_pkg::RELEASE)) u_phase_loop (
        .clk(clk), .rst(rst), .cen(cen), .din(state_in_iii), .dout(state_ii_raw)
    );

    eg_delay_line #(.width(10), .stages(`EG_PAD_STAGES), .rst_val(MAX_ATT)) u_pad (
        .clk(clk), .rst(rst), .cen(cen), .din(eg_viii), .dout(eg_out)
    );

    // release only ever leaves through a new key-on
    a_release_exit: assert property (@(posedge clk) disable iff (rst)
        cen && state_ii == eg_pkg::RELEASE
        |=> state_in_iii inside {eg_pkg::RELEASE, eg_pkg::ATTACK});

    // counter moves only on the frame strobe from the timer
    a_cnt_frame: assert property (@(posedge clk) disable iff (rst)
        !(cen && zero) |=> $stable(eg_cnt));

endmodule

/* src/eg_pkg.sv */
// envelope generator types
// phase encoding and per-slot field widths
package eg_pkg;

    typedef enum logic [1:0] {
        ATTACK  = 2'd0,
        DECAY1  = 2'd1,
        DECAY2  = 2'd2,
        RELEASE = 2'd3
    } eg_phase_t;

    typedef logic [4:0] slot_t;
    typedef logic [4:0] rate_t;     // attack, decay1, decay2
    typedef logic [3:0] rrate_t;    // release rate, LSB forced to one later
    typedef logic [9:0] level_t;    // 1 LSB ~0.094 dB, all ones is silence
    typedef logic [3:0] d1l_t;
    typedef logic [6:0] tl_t;
    typedef logic [1:0] ks_t;
    typedef logic [4:0] keycode_t;
    typedef logic [1:0] ams_t;

endpackage

/* src/eg_slot_regs.sv */
// per-slot envelope parameters and key bits
// host writes by slot, pipeline reads one stage at a time
`timescale 1ns/100ps
`include "eg_config.svh"

module eg_slot_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  eg_pkg::slot_t     slot,
    input  logic              cfg_we,
    input  eg_pkg::slot_t     cfg_slot,
    input  eg_pkg::rate_t     cfg_ar,
    input  eg_pkg::rate_t     cfg_d1r,
    input  eg_pkg::rate_t     cfg_d2r,
    input  eg_pkg::rrate_t    cfg_rr,
    input  eg_pkg::d1l_t      cfg_d1l,
    input  eg_pkg::tl_t       cfg_tl,
    input  eg_pkg::ks_t       cfg_ks,
    input  eg_pkg::keycode_t  cfg_keycode,
    input  eg_pkg::ams_t      cfg_ams,
    input  logic              cfg_amsen,
    input  logic              kon_we,
    input  eg_pkg::slot_t     kon_slot,
    input  logic              kon_val,
    output eg_pkg::d1l_t      d1l_i,
    output eg_pkg::rate_t     arate_ii,
    output eg_pkg::rate_t     rate1_ii,
    output eg_pkg::rate_t     rate2_ii,
    output eg_pkg::rrate_t    rrate_ii,
    output logic              keyon_ii,
    output eg_pkg::keycode_t  keycode_iii,
    output eg_pkg::ks_t       ks_iii,
    output eg_pkg::tl_t       tl_vii,
    output eg_pkg::ams_t      ams_vii,
    output logic              amsen_vii
);

    eg_pkg::rate_t    ar_mem    [`EG_SLOTS];
    eg_pkg::rate_t    d1r_mem   [`EG_SLOTS];
    eg_pkg::rate_t    d2r_mem   [`EG_SLOTS];
    eg_pkg::rrate_t   rr_mem    [`EG_SLOTS];
    eg_pkg::d1l_t     d1l_mem   [`EG_SLOTS];
    eg_pkg::tl_t      tl_mem    [`EG_SLOTS];
    eg_pkg::ks_t      ks_mem    [`EG_SLOTS];
    eg_pkg::keycode_t kc_mem    [`EG_SLOTS];
    eg_pkg::ams_t     ams_mem   [`EG_SLOTS];
    logic             amsen_mem [`EG_SLOTS];
    logic [`EG_SLOTS-1:0] kon_bits;

    // slot seen by each stage one enable after the fetch
    eg_pkg::slot_t slot_ii, slot_iii, slot_vii;

    assign slot_ii  = slot - 5'd1;
    assign slot_iii = slot - 5'd2;
    assign slot_vii = slot - 5'd6;

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            ar_mem[cfg_slot]    <= cfg_ar;
            d1r_mem[cfg_slot]   <= cfg_d1r;
            d2r_mem[cfg_slot]   <= cfg_d2r;
            rr_mem[cfg_slot]    <= cfg_rr;
            d1l_mem[cfg_slot]   <= cfg_d1l;
            ks_mem[cfg_slot]    <= cfg_ks;
            kc_mem[cfg_slot]    <= cfg_keycode;
            ams_mem[cfg_slot]   <= cfg_ams;
            amsen_mem[cfg_slot] <= cfg_amsen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tl_mem   <= '{default: '0};
            kon_bits <= '0;
        end else begin
            if (cfg_we)
                tl_mem[cfg_slot] <= cfg_tl;
            if (kon_we)
                kon_bits[kon_slot] <= kon_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            keyon_ii  <= 1'b0;
            tl_vii    <= '0;
            amsen_vii <= 1'b0;
        end else if (cen) begin
            d1l_i       <= d1l_mem[slot];
            arate_ii    <= ar_mem[slot_ii];
            rate1_ii    <= d1r_mem[slot_ii];
            rate2_ii    <= d2r_mem[slot_ii];
            rrate_ii    <= rr_mem[slot_ii];
            keyon_ii    <= kon_bits[slot_ii];
            keycode_iii <= kc_mem[slot_iii];
            ks_iii      <= ks_mem[slot_iii];
            tl_vii      <= tl_mem[slot_vii];
            ams_vii     <= ams_mem[slot_vii];
            amsen_vii   <= amsen_mem[slot_vii];
        end
    end

    a_we_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({cfg_we, kon_we}));

endmodule

/* src/eg_timer.sv */
// slot sequencer and envelope counter
// counter steps once every three sample frames
`timescale 1ns/100ps
`include "eg_config.svh"

module eg_timer (
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    output eg_pkg::slot_t slot,
    output logic          zero,
    output logic [14:0]   eg_cnt,
    output eg_pkg::slot_t eg_slot
);

    localparam eg_pkg::slot_t LAT       = eg_pkg::slot_t'(`EG_LATENCY);
    localparam eg_pkg::slot_t LAST_SLOT = eg_pkg::slot_t'(`EG_SLOTS - 1);

    logic [1:0] frame_div;  // counts frames 0..2

    always_ff @(posedge clk) begin
        if (rst) begin
            slot      <= '0;
            zero      <= 1'b0;
            eg_slot   <= 5'd0 - LAT - 5'd1;  // slot 0 is fetched on the first enable
            frame_div <= 2'd0;
            eg_cnt    <= '0;
        end else if (cen) begin
            slot    <= slot + 5'd1;
            zero    <= (slot == LAST_SLOT - 5'd1);
            eg_slot <= slot - LAT;  // slot fetched LAT enables ago
            if (zero) begin
                if (frame_div == 2'd2) begin
                    frame_div <= 2'd0;
                    eg_cnt    <= eg_cnt + 15'd1;
                end else begin
                    frame_div <= frame_div + 2'd1;
                end
            end
        end
    end

    a_zero_slot: assert property (@(posedge clk) disable iff (rst)
        zero == (slot == LAST_SLOT));

endmodule

/* src/eg_top.sv */
// envelope generator top level
// timer, parameter store and envelope pipeline
`timescale 1ns/100ps

module eg_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              cfg_we,
    input  eg_pkg::slot_t     cfg_slot,
    input  eg_pkg::rate_t     cfg_ar,
    input  eg_pkg::rate_t     cfg_d1r,
    input  eg_pkg::rate_t     cfg_d2r,
    input  eg_pkg::rrate_t    cfg_rr,
    input  eg_pkg::d1l_t      cfg_d1l,
    input  eg_pkg::tl_t       cfg_tl,
    input  eg_pkg::ks_t       cfg_ks,
    input  eg_pkg::keycode_t  cfg_keycode,
    input  eg_pkg::ams_t      cfg_ams,
    input  logic              cfg_amsen,
    input  logic              kon_we,
    input  eg_pkg::slot_t     kon_slot,
    input  logic              kon_val,
    input  logic [6:0]        am,
    output eg_pkg::level_t    eg_out,
    output eg_pkg::slot_t     eg_slot,
    output logic              pg_rst
);

    eg_pkg::slot_t    slot;
    logic             zero;
    logic [14:0]      eg_cnt;
    eg_pkg::d1l_t     d1l_i;
    eg_pkg::rate_t    arate_ii, rate1_ii, rate2_ii;
    eg_pkg::rrate_t   rrate_ii;
    logic             keyon_ii;
    eg_pkg::keycode_t keycode_iii;
    eg_pkg::ks_t      ks_iii;
    eg_pkg::tl_t      tl_vii;
    eg_pkg::ams_t     ams_vii;
    logic             amsen_vii;

    eg_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .slot    (slot),
        .zero    (zero),
        .eg_cnt  (eg_cnt),
        .eg_slot (eg_slot)
    );

    eg_slot_regs u_slot_regs (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .slot        (slot),
        .cfg_we      (cfg_we),
        .cfg_slot    (cfg_slot),
        .cfg_ar      (cfg_ar),
        .cfg_d1r     (cfg_d1r),
        .cfg_d2r     (cfg_d2r),
        .cfg_rr      (cfg_rr),
        .cfg_d1l     (cfg_d1l),
        .cfg_tl      (cfg_tl),
        .cfg_ks      (cfg_ks),
        .cfg_keycode (cfg_keycode),
        .cfg_ams     (cfg_ams),
        .cfg_amsen   (cfg_amsen),
        .kon_we      (kon_we),
        .kon_slot    (kon_slot),
        .kon_val     (kon_val),
        .d1l_i       (d1l_i),
        .arate_ii    (arate_ii),
        .rate1_ii    (rate1_ii),
        .rate2_ii    (rate2_ii),
        .rrate_ii    (rrate_ii),
        .keyon_ii    (keyon_ii),
        .keycode_iii (keycode_iii),
        .ks_iii      (ks_iii),
        .tl_vii      (tl_vii),
        .ams_vii     (ams_vii),
        .amsen_vii   (amsen_vii)
    );

    eg_envelope u_envelope (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .zero        (zero),
        .eg_cnt      (eg_cnt),
        .d1l_i       (d1l_i),
        .arate_ii    (arate_ii),
        .rate1_ii    (rate1_ii),
        .rate2_ii    (rate2_ii),
        .rrate_ii    (rrate_ii),
        .keyon_ii    (keyon_ii),
        .keycode_iii (keycode_iii),
        .ks_iii      (ks_iii),
        .tl_vii      (tl_vii),
        .ams_vii     (ams_vii),
        .amsen_vii   (amsen_vii),
        .am          (am),
        .pg_rst      (pg_rst),
        .eg_out      (eg_out)
    );

endmodule

/* test/tb_eg.sv */
// testbench for the envelope generator
// key-on, decay, release, tl/am sum and clock-enable freeze
`timescale 1ns/100ps
`include "eg_config.svh"

module tb_eg;

    localparam int FRAME_WAIT = 3 * `EG_SLOTS;  // enables allowed between two samples of a slot
    localparam int MAX_ATT    = `EG_MAX_ATT;

    logic             clk, rst, cen;
    logic             cfg_we;
    eg_pkg::slot_t    cfg_slot;
    eg_pkg::rate_t    cfg_ar, cfg_d1r, cfg_d2r;
    eg_pkg::rrate_t   cfg_rr;
    eg_pkg::d1l_t     cfg_d1l;
    eg_pkg::tl_t      cfg_tl;
    eg_pkg::ks_t      cfg_ks;
    eg_pkg::keycode_t cfg_keycode;
    eg_pkg::ams_t     cfg_ams;
    logic             cfg_amsen;
    logic             kon_we;
    eg_pkg::slot_t    kon_slot;
    logic             kon_val;
    logic [6:0]       am;
    eg_pkg::level_t   eg_out;
    eg_pkg::slot_t    eg_slot;
    logic             pg_rst;

    int lvl  [`EG_SLOTS];   // last eg_out seen per slot
    int seen [`EG_SLOTS];   // samples per slot, one per frame
    int snap [`EG_SLOTS];
    int pulses;
    bit upd_d;              // previous edge moved the pipeline
    bit kon_seen;

    eg_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // outputs sampled before the edge, so they are the results of the previous enable
    always @(posedge clk) begin
        if (upd_d) begin
            lvl[eg_slot]  = eg_out;
            seen[eg_slot] = seen[eg_slot] + 1;
            if (pg_rst)
                pulses = pulses + 1;
        end
        upd_d = cen && !rst;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input bit ok, input string msg);
        assert (ok) else stop_on_error($sformatf("[FAIL] t=%0t: %s", $realtime, msg));
    endtask

    task automatic timed_out(input string what);
        stop_on_error($sformatf("timeout while waiting for %s", what));
    endtask

    a_frozen: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(eg_out) && $stable(eg_slot) && $stable(pg_rst))
        else stop_on_error($sformatf("[FAIL] t=%0t: outputs moved with cen low", $realtime));

    a_no_early_pg: assert property (@(posedge clk) disable iff (rst) !kon_seen |-> !pg_rst)
        else stop_on_error($sformatf("[FAIL] t=%0t: pg_rst before any key-on", $realtime));

    // attenuation for a slot resting at level 0
    function automatic int expected_att(input int tl, input int ams, input bit amsen,
                                        input int am_v);
        int sum;
        sum = tl * 8;
        if (amsen && ams != 0)
            sum = sum + (am_v << (ams - 1));
        if (tl == 127 || sum > MAX_ATT)
            sum = MAX_ATT;
        return sum;
    endfunction

    task automatic wait_frame(input int s);
        int n;
        int cycles;
        n = seen[s];
        cycles = 0;
        while (seen[s] == n) begin
            @(negedge clk);
            cycles++;
            if (cycles > FRAME_WAIT)
                timed_out($sformatf("the next output of slot %0d", s));
        end
    endtask

    task automatic wait_level(input int s, input int v, input int max_frames,
                              input string what);
        int frames;
        frames = 0;
        while (lvl[s] != v) begin
            wait_frame(s);
            frames++;
            if (lvl[s] != v && frames >= max_frames)
                timed_out(what);
        end
    endtask

    task automatic write_cfg(input int s, input int ar, input int d1r, input int d2r,
                             input int rr, input int d1l, input int tl, input int ams,
                             input bit amsen);
        @(posedge clk);
        cfg_we      <= 1'b1;
        cfg_slot    <= 5'(s);
        cfg_ar      <= 5'(ar);
        cfg_d1r     <= 5'(d1r);
        cfg_d2r     <= 5'(d2r);
        cfg_rr      <= 4'(rr);
        cfg_d1l     <= 4'(d1l);
        cfg_tl      <= 7'(tl);
        cfg_ks      <= 2'd0;
        cfg_keycode <= 5'd0;     // no key scaling in these tests
        cfg_ams     <= 2'(ams);
        cfg_amsen   <= amsen;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic write_key(input int s, input bit val);
        @(posedge clk);
        kon_we   <= 1'b1;
        kon_slot <= 5'(s);
        kon_val  <= val;
        if (val)
            kon_seen = 1'b1;
        @(posedge clk);
        kon_we <= 1'b0;
    endtask

    initial begin
        int a, b, prev, frames, tl, ams, amsen_r, am_r, exp_v;
        int frozen_out, frozen_slot, frozen_pg;
        void'($urandom(75));
        rst = 1'b1;
        cen = 1'b1;
        cfg_we = 1'b0;
        cfg_slot = '0;
        cfg_ar = '0;
        cfg_d1r = '0;
        cfg_d2r = '0;
        cfg_rr = '0;
        cfg_d1l = '0;
        cfg_tl = '0;
        cfg_ks = '0;
        cfg_keycode = '0;
        cfg_ams = '0;
        cfg_amsen = 1'b0;
        kon_we = 1'b0;
        kon_slot = '0;
        kon_val = 1'b0;
        am = '0;
        pulses = 0;
        kon_seen = 1'b0;
        for (int s = 0; s < `EG_SLOTS; s++) begin
            lvl[s] = -1;
            seen[s] = 0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int s = 0; s < `EG_SLOTS; s++)
            write_cfg(s, 0, 0, 0, 15, 0, 0, 0, 1'b0);

        // every slot silent once the pipeline has filled
        repeat (2) wait_frame(0);
        for (int s = 0; s < `EG_SLOTS; s++)
            check(lvl[s] == MAX_ATT, $sformatf("slot %0d reads %0d after reset", s, lvl[s]));
        check(pulses == 0, "pg_rst pulsed before any key-on");

        a = $urandom % `EG_SLOTS;
        b = (a + 1 + $urandom % (`EG_SLOTS - 1)) % `EG_SLOTS;

        // ar 31 jumps to peak, one pg_rst
        write_cfg(a, 31, 0, 0, 15, 0, 0, 0, 1'b0);
        write_key(a, 1'b1);
        wait_level(a, 0, 2, $sformatf("slot %0d to reach level 0 in two frames", a));
        wait_frame(a);
        check(pulses == 1, $sformatf("%0d pg_rst pulses for one key-on", pulses));

        // tl and am sum on a slot held at level 0
        for (int i = 0; i < 10; i++) begin
            tl = (i == 9) ? 127 : $urandom % 128;
            ams = $urandom % 4;
            amsen_r = $urandom % 2;
            am_r = $urandom % 128;
            exp_v = expected_att(tl, ams, amsen_r != 0, am_r);
            @(posedge clk);
            am <= 7'(am_r);
            write_cfg(a, 31, 0, 0, 15, 0, tl, ams, amsen_r != 0);
            repeat (2) wait_frame(a);
            check(lvl[a] == exp_v, $sformatf("slot %0d tl %0d ams %0d amsen %0d am %0d: %0d, want %0d",
                  a, tl, ams, amsen_r, am_r, lvl[a], exp_v));
        end

        // freeze with cen low
        @(posedge clk);
        cen <= 1'b0;
        @(negedge clk);
        frozen_out = eg_out;
        frozen_slot = eg_slot;
        frozen_pg = pg_rst;
        repeat (20) begin
            @(negedge clk);
            check(eg_out == frozen_out && eg_slot == frozen_slot && pg_rst == frozen_pg,
                  "outputs changed while cen was low");
        end
        @(posedge clk);
        cen <= 1'b1;

        // attack to peak, then decay1 up to d1l 1 and hold with d2r 0
        write_cfg(b, 28, 23, 0, 15, 1, 0, 0, 1'b0);
        write_key(b, 1'b1);
        wait_level(b, 0, 400, $sformatf("attack peak on slot %0d", b));
        prev = 0;
        frames = 0;
        while (lvl[b] < 32) begin
            wait_frame(b);
            check(lvl[b] >= prev, $sformatf("decay level fell from %0d to %0d", prev, lvl[b]));
            prev = lvl[b];
            frames++;
            if (frames > 1000)
                timed_out("decay1 to reach the d1l level");
        end
        repeat (20) begin
            check(lvl[b] == 32, $sformatf("slot %0d at %0d, want 32 in decay2", b, lvl[b]));
            wait_frame(b);
        end

        // release back to silence, other slots untouched
        for (int s = 0; s < `EG_SLOTS; s++)
            snap[s] = lvl[s];
        write_cfg(b, 28, 23, 0, 15, 1, 0, 0, 1'b0);
        write_key(b, 1'b0);
        prev = lvl[b];
        frames = 0;
        while (lvl[b] != MAX_ATT) begin
            wait_frame(b);
            check(lvl[b] >= prev, $sformatf("release level fell from %0d to %0d", prev, lvl[b]));
            for (int s = 0; s < `EG_SLOTS; s++)
                if (s != b)
                    check(lvl[s] == snap[s], $sformatf("slot %0d moved to %0d", s, lvl[s]));
            prev = lvl[b];
            frames++;
            if (frames > 2000)
                timed_out("release to reach full attenuation");
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
